// ==== src/tlb_pkg.sv ====
`default_nettype none

package tlb_pkg;

    // ************************************************************
    // Sizes and widths
    // ************************************************************
    localparam int TLB_ENTRY_NUM = 16;
    localparam int TLB_INDEX_W = 4;
    localparam int PAGE_OFFSET_W = 12;
    localparam int PAGE_SEL_BIT = 12;    // Picks the odd page of the pair.

    typedef logic [31:0]              word_t;
    typedef logic [TLB_INDEX_W-1:0]   tlb_index_t;
    typedef logic [18:0]              vpn2_t;
    typedef logic [7:0]               asid_t;
    typedef logic [19:0]              pfn_t;
    typedef logic [2:0]               cache_attr_t;

    localparam cache_attr_t CACHE_UNCACHED = 3'd2;     // kseg1.
    localparam cache_attr_t CACHE_CACHEABLE = 3'd3;    // kseg0.

    // ************************************************************
    // CP0 word layouts
    // ************************************************************
    localparam int HI_VPN2_MSB = 31;
    localparam int HI_VPN2_LSB = 13;
    localparam int HI_ASID_MSB = 7;
    localparam int HI_ASID_LSB = 0;

    localparam int LO_PFN_MSB = 25;
    localparam int LO_PFN_LSB = 6;
    localparam int LO_C_MSB = 5;
    localparam int LO_C_LSB = 3;
    localparam int LO_D_BIT = 2;
    localparam int LO_V_BIT = 1;
    localparam int LO_G_BIT = 0;

    typedef struct packed {
        pfn_t        pfn;
        cache_attr_t c;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        vpn2_t     vpn2;
        asid_t     asid;
        logic      g;
        tlb_page_t page0;    // Even page.
        tlb_page_t page1;    // Odd page.
    } tlb_entry_t;

    typedef struct packed {
        word_t       paddr;
        logic        miss;
        logic        d;
        logic        v;
        cache_attr_t c;
    } tlb_result_t;

    // Searches every entry at once. Returns the hit flag and the lowest matching index.
    function automatic logic tlb_match_lowest(
        input  tlb_entry_t [TLB_ENTRY_NUM-1:0] entries,
        input  vpn2_t                          vpn2,
        input  asid_t                          asid,
        output tlb_index_t                     index
    );
        logic hit;
        hit = 1'b0;
        index = '0;
        // Walk downward so the lowest match is the one left standing.
        for (int i = TLB_ENTRY_NUM - 1; i >= 0; i--) begin
            if (entries[i].vpn2 == vpn2 && (entries[i].g || entries[i].asid == asid)) begin
                hit = 1'b1;
                index = tlb_index_t'(i);
            end
        end
        return hit;
    endfunction

endpackage

`default_nettype wire

// ==== src/tlb_entry_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module tlb_entry_store (
    input  wire logic                                         clk,
    input  wire logic                                         rst,
    input  wire logic                                         write_i,
    input  wire tlb_pkg::tlb_index_t                          rw_index_i,
    input  wire tlb_pkg::word_t                               entry_hi_i,
    input  wire tlb_pkg::word_t                               entry_lo0_i,
    input  wire tlb_pkg::word_t                               entry_lo1_i,
    output tlb_pkg::tlb_entry_t [tlb_pkg::TLB_ENTRY_NUM-1:0]  entries_o,
    output tlb_pkg::word_t                                    entry_hi_o,
    output tlb_pkg::word_t                                    entry_lo0_o,
    output tlb_pkg::word_t                                    entry_lo1_o
);

    tlb_pkg::tlb_entry_t [tlb_pkg::TLB_ENTRY_NUM-1:0] entries_q;
    tlb_pkg::tlb_entry_t wr_entry;
    tlb_pkg::tlb_entry_t rd_entry;

    function automatic tlb_pkg::tlb_page_t decode_lo(input tlb_pkg::word_t lo);
        tlb_pkg::tlb_page_t page;
        page.pfn = lo[tlb_pkg::LO_PFN_MSB:tlb_pkg::LO_PFN_LSB];
        page.c = lo[tlb_pkg::LO_C_MSB:tlb_pkg::LO_C_LSB];
        page.d = lo[tlb_pkg::LO_D_BIT];
        page.v = lo[tlb_pkg::LO_V_BIT];
        return page;
    endfunction

    function automatic tlb_pkg::word_t encode_lo(input tlb_pkg::tlb_page_t page, input logic g);
        tlb_pkg::word_t lo;
        lo = '0;    // Unused fields read back as zero.
        lo[tlb_pkg::LO_PFN_MSB:tlb_pkg::LO_PFN_LSB] = page.pfn;
        lo[tlb_pkg::LO_C_MSB:tlb_pkg::LO_C_LSB] = page.c;
        lo[tlb_pkg::LO_D_BIT] = page.d;
        lo[tlb_pkg::LO_V_BIT] = page.v;
        lo[tlb_pkg::LO_G_BIT] = g;
        return lo;
    endfunction

    always_comb begin
        wr_entry.vpn2 = entry_hi_i[tlb_pkg::HI_VPN2_MSB:tlb_pkg::HI_VPN2_LSB];
        wr_entry.asid = entry_hi_i[tlb_pkg::HI_ASID_MSB:tlb_pkg::HI_ASID_LSB];
        // An entry is global only if both halves say so.
        wr_entry.g = entry_lo0_i[tlb_pkg::LO_G_BIT] & entry_lo1_i[tlb_pkg::LO_G_BIT];
        wr_entry.page0 = decode_lo(entry_lo0_i);
        wr_entry.page1 = decode_lo(entry_lo1_i);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entries_q <= '0;
        end else if (write_i) begin
            entries_q[rw_index_i] <= wr_entry;    // tlbwi and tlbwr.
        end
    end

    // tlbr read-back of the indexed slot.
    always_comb begin
        rd_entry = entries_q[rw_index_i];
        entry_hi_o = '0;
        entry_hi_o[tlb_pkg::HI_VPN2_MSB:tlb_pkg::HI_VPN2_LSB] = rd_entry.vpn2;
        entry_hi_o[tlb_pkg::HI_ASID_MSB:tlb_pkg::HI_ASID_LSB] = rd_entry.asid;
        entry_lo0_o = encode_lo(rd_entry.page0, rd_entry.g);
        entry_lo1_o = encode_lo(rd_entry.page1, rd_entry.g);
    end

    assign entries_o = entries_q;

endmodule

`default_nettype wire

// ==== src/tlb_lookup.sv ====
`timescale 1ns/1ns
`default_nettype none

module tlb_lookup (
    input  wire tlb_pkg::tlb_entry_t [tlb_pkg::TLB_ENTRY_NUM-1:0] entries_i,
    input  wire tlb_pkg::word_t                                   vaddr_i,
    input  wire tlb_pkg::asid_t                                   asid_i,
    output tlb_pkg::tlb_result_t                                  result_o
);

    tlb_pkg::vpn2_t      vpn2;
    logic                unmapped;
    logic                kseg1;
    logic                hit;
    tlb_pkg::tlb_index_t hit_index;
    tlb_pkg::tlb_entry_t hit_entry;
    tlb_pkg::tlb_page_t  page;

    assign vpn2 = vaddr_i[tlb_pkg::HI_VPN2_MSB:tlb_pkg::HI_VPN2_LSB];

    // kseg0 and kseg1 both start with 2'b10. Bit 29 tells them apart.
    assign unmapped = (vaddr_i[31:30] == 2'b10);
    assign kseg1 = vaddr_i[29];

    // ************************************************************
    // Associative search
    // ************************************************************
    always_comb begin
        hit = tlb_pkg::tlb_match_lowest(entries_i, vpn2, asid_i, hit_index);
    end

    assign hit_entry = entries_i[hit_index];
    assign page = vaddr_i[tlb_pkg::PAGE_SEL_BIT] ? hit_entry.page1 : hit_entry.page0;

    // ************************************************************
    // Result assembly
    // ************************************************************
    always_comb begin
        result_o = '0;
        if (unmapped) begin
            result_o.paddr = {3'b000, vaddr_i[28:0]};
            result_o.miss = 1'b0;
            result_o.d = 1'b1;
            result_o.v = 1'b1;
            result_o.c = kseg1 ? tlb_pkg::CACHE_UNCACHED : tlb_pkg::CACHE_CACHEABLE;
        end else if (hit) begin
            // A hit on an invalid page is still a hit. The pipeline checks v.
            result_o.paddr = {page.pfn, vaddr_i[tlb_pkg::PAGE_OFFSET_W-1:0]};
            result_o.miss = 1'b0;
            result_o.d = page.d;
            result_o.v = page.v;
            result_o.c = page.c;
        end else begin
            result_o.miss = 1'b1;    // Everything else stays zero.
        end
    end

endmodule

`default_nettype wire

// ==== src/tlb_probe.sv ====
`timescale 1ns/1ns
`default_nettype none

module tlb_probe (
    input  wire tlb_pkg::tlb_entry_t [tlb_pkg::TLB_ENTRY_NUM-1:0] entries_i,
    input  wire tlb_pkg::word_t                                   entry_hi_i,
    output tlb_pkg::word_t                                        probe_index_o
);

    tlb_pkg::vpn2_t      probe_vpn2;
    tlb_pkg::asid_t      probe_asid;
    logic                probe_hit;
    tlb_pkg::tlb_index_t probe_index;

    assign probe_vpn2 = entry_hi_i[tlb_pkg::HI_VPN2_MSB:tlb_pkg::HI_VPN2_LSB];
    assign probe_asid = entry_hi_i[tlb_pkg::HI_ASID_MSB:tlb_pkg::HI_ASID_LSB];

    // tlbp always searches the array, even for unmapped EntryHi values.
    always_comb begin
        probe_hit = tlb_pkg::tlb_match_lowest(entries_i, probe_vpn2, probe_asid, probe_index);
    end

    // Index register format.
    // Bit 31 is the probe-failure flag.
    always_comb begin
        probe_index_o = '0;
        probe_index_o[31] = ~probe_hit;
        if (probe_hit) begin
            probe_index_o[tlb_pkg::TLB_INDEX_W-1:0] = probe_index;
        end
    end

endmodule

`default_nettype wire

// ==== src/tlb.sv ====
`timescale 1ns/1ns
`default_nettype none

module tlb (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire tlb_pkg::asid_t       asid_i,

    // Translation ports.
    input  wire tlb_pkg::word_t       inst_vaddr_i,
    input  wire tlb_pkg::word_t       data_vaddr_i,
    output tlb_pkg::tlb_result_t      inst_result_o,
    output tlb_pkg::tlb_result_t      data_result_o,

    // tlbwi, tlbwr and tlbr.
    input  wire tlb_pkg::tlb_index_t  rw_index_i,
    input  wire logic                 write_i,
    input  wire tlb_pkg::word_t       entry_hi_i,
    input  wire tlb_pkg::word_t       entry_lo0_i,
    input  wire tlb_pkg::word_t       entry_lo1_i,
    output tlb_pkg::word_t            entry_hi_o,
    output tlb_pkg::word_t            entry_lo0_o,
    output tlb_pkg::word_t            entry_lo1_o,

    // tlbp.
    output tlb_pkg::word_t            probe_index_o
);

    tlb_pkg::tlb_entry_t [tlb_pkg::TLB_ENTRY_NUM-1:0] entries;

    // ************************************************************
    // Entry store
    // ************************************************************
    tlb_entry_store u_entry_store (
        .clk         (clk),
        .rst         (rst),
        .write_i     (write_i),
        .rw_index_i  (rw_index_i),
        .entry_hi_i  (entry_hi_i),
        .entry_lo0_i (entry_lo0_i),
        .entry_lo1_i (entry_lo1_i),
        .entries_o   (entries),
        .entry_hi_o  (entry_hi_o),
        .entry_lo0_o (entry_lo0_o),
        .entry_lo1_o (entry_lo1_o)
    );

    // ************************************************************
    // Translation
    // ************************************************************
    // Both ports see the same entries and ASID in the same cycle.
    tlb_lookup u_inst_lookup (
        .entries_i (entries),
        .vaddr_i   (inst_vaddr_i),
        .asid_i    (asid_i),
        .result_o  (inst_result_o)
    );

    tlb_lookup u_data_lookup (
        .entries_i (entries),
        .vaddr_i   (data_vaddr_i),
        .asid_i    (asid_i),
        .result_o  (data_result_o)
    );

    // ************************************************************
    // Probe
    // ************************************************************
    tlb_probe u_probe (
        .entries_i     (entries),
        .entry_hi_i    (entry_hi_i),    // The same EntryHi word is the probe key.
        .probe_index_o (probe_index_o)
    );

endmodule

`default_nettype wire

// ==== verification/tlb_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module tlb_tb;

    localparam int CYCLE_LIMIT = 2000;    // About twice the stimulus length.
    localparam int NUM_WRITES = 450;
    localparam tlb_pkg::word_t HI_MASK = 32'hFFFF_E0FF;    // VPN2 and ASID.
    localparam tlb_pkg::word_t LO_MASK = 32'h03FF_FFFE;    // PFN, C, D and V.

    logic                 clk;
    logic                 rst;
    tlb_pkg::asid_t       asid;
    tlb_pkg::word_t       inst_vaddr;
    tlb_pkg::word_t       data_vaddr;
    tlb_pkg::tlb_result_t inst_result;
    tlb_pkg::tlb_result_t data_result;
    tlb_pkg::tlb_index_t  rw_index;
    logic                 write_strobe;
    tlb_pkg::word_t       entry_hi;
    tlb_pkg::word_t       entry_lo0;
    tlb_pkg::word_t       entry_lo1;
    tlb_pkg::word_t       entry_hi_rd;
    tlb_pkg::word_t       entry_lo0_rd;
    tlb_pkg::word_t       entry_lo1_rd;
    tlb_pkg::word_t       probe_index;

    // Reference copy of every slot, kept as the raw CP0 words that were written.
    tlb_pkg::word_t m_hi [tlb_pkg::TLB_ENTRY_NUM];
    tlb_pkg::word_t m_lo0 [tlb_pkg::TLB_ENTRY_NUM];
    tlb_pkg::word_t m_lo1 [tlb_pkg::TLB_ENTRY_NUM];

    logic [31:0] rng_state;
    int errors = 0;
    int cycles = 0;

    tlb u_tlb (
        .clk           (clk),
        .rst           (rst),
        .asid_i        (asid),
        .inst_vaddr_i  (inst_vaddr),
        .data_vaddr_i  (data_vaddr),
        .inst_result_o (inst_result),
        .data_result_o (data_result),
        .rw_index_i    (rw_index),
        .write_i       (write_strobe),
        .entry_hi_i    (entry_hi),
        .entry_lo0_i   (entry_lo0),
        .entry_lo1_i   (entry_lo1),
        .entry_hi_o    (entry_hi_rd),
        .entry_lo0_o   (entry_lo0_rd),
        .entry_lo1_o   (entry_lo1_rd),
        .probe_index_o (probe_index)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles.", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // ************************************************************
    // Reference model
    // ************************************************************
    function automatic logic entry_matches(input int i, input tlb_pkg::vpn2_t vpn2,
                                           input tlb_pkg::asid_t a);
        return m_hi[i][31:13] == vpn2 && ((m_lo0[i][0] & m_lo1[i][0]) || m_hi[i][7:0] == a);
    endfunction

    function automatic tlb_pkg::tlb_result_t expect_lookup(input tlb_pkg::word_t vaddr,
                                                           input tlb_pkg::asid_t a);
        tlb_pkg::tlb_result_t res;
        tlb_pkg::word_t       lo;
        logic                 found;
        res = '0;
        found = 1'b0;
        if (vaddr[31:30] == 2'b10) begin
            res.paddr = vaddr & 32'h1FFF_FFFF;
            res.d = 1'b1;
            res.v = 1'b1;
            res.c = vaddr[29] ? 3'd2 : 3'd3;    // kseg1 is uncached.
        end else begin
            for (int i = 0; i < tlb_pkg::TLB_ENTRY_NUM; i++) begin
                if (!found && entry_matches(i, vaddr[31:13], a)) begin
                    found = 1'b1;
                    lo = vaddr[12] ? m_lo1[i] : m_lo0[i];
                    res.paddr = {lo[25:6], vaddr[11:0]};
                    res.c = lo[5:3];
                    res.d = lo[2];
                    res.v = lo[1];
                end
            end
            res.miss = ~found;
        end
        return res;
    endfunction

    function automatic tlb_pkg::word_t expect_probe(input tlb_pkg::word_t hi);
        tlb_pkg::word_t idx_word;
        logic           found;
        idx_word = 32'h8000_0000;    // Probe failure until a match turns up.
        found = 1'b0;
        for (int i = 0; i < tlb_pkg::TLB_ENTRY_NUM; i++) begin
            if (!found && entry_matches(i, hi[31:13], hi[7:0])) begin
                found = 1'b1;
                idx_word = 32'(i);
            end
        end
        return idx_word;
    endfunction

    // ************************************************************
    // Checks and drivers
    // ************************************************************
    task automatic check_word(input string name, input tlb_pkg::word_t exp,
                              input tlb_pkg::word_t act);
        assert (act === exp) else begin
            errors++;
            $display("Error: %s expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_result(input string name, input tlb_pkg::tlb_result_t exp,
                                input tlb_pkg::tlb_result_t act);
        assert (act === exp) else begin
            errors++;
            $display("Error: %s expected %h, got %h", name, exp, act);
        end
    endtask

    // Outputs are compared in the middle of the cycle.
    task automatic check_cycle();
        logic g;
        @(negedge clk);
        g = m_lo0[rw_index][0] & m_lo1[rw_index][0];
        check_result("inst_result_o", expect_lookup(inst_vaddr, asid), inst_result);
        check_result("data_result_o", expect_lookup(data_vaddr, asid), data_result);
        check_word("entry_hi_o", m_hi[rw_index] & HI_MASK, entry_hi_rd);
        check_word("entry_lo0_o", (m_lo0[rw_index] & LO_MASK) | {31'b0, g}, entry_lo0_rd);
        check_word("entry_lo1_o", (m_lo1[rw_index] & LO_MASK) | {31'b0, g}, entry_lo1_rd);
        check_word("probe_index_o", expect_probe(entry_hi), probe_index);
    endtask

    task automatic next_edge();
        @(posedge clk);
        if (write_strobe) begin    // The DUT takes the same words at this edge.
            m_hi[rw_index] = entry_hi;
            m_lo0[rw_index] = entry_lo0;
            m_lo1[rw_index] = entry_lo1;
        end
    endtask

    task automatic write_entry(input tlb_pkg::tlb_index_t idx, input tlb_pkg::word_t hi,
                               input tlb_pkg::word_t lo0, input tlb_pkg::word_t lo1);
        next_edge();
        write_strobe <= 1'b1;
        rw_index <= idx;
        entry_hi <= hi;
        entry_lo0 <= lo0;
        entry_lo1 <= lo1;
        check_cycle();
    endtask

    task automatic lookup(input tlb_pkg::tlb_index_t idx, input tlb_pkg::asid_t a,
                          input tlb_pkg::word_t iaddr, input tlb_pkg::word_t daddr);
        next_edge();
        write_strobe <= 1'b0;
        rw_index <= idx;
        asid <= a;
        inst_vaddr <= iaddr;
        data_vaddr <= daddr;
        check_cycle();
    endtask

    task automatic probe_key(input tlb_pkg::word_t hi);
        next_edge();
        write_strobe <= 1'b0;
        entry_hi <= hi;
        check_cycle();
    endtask

    initial begin
        tlb_pkg::word_t r0;
        tlb_pkg::word_t r1;
        tlb_pkg::word_t hi;
        tlb_pkg::word_t lo0;
        tlb_pkg::word_t lo1;

        rng_state = 32'h9b3a;
        for (int i = 0; i < tlb_pkg::TLB_ENTRY_NUM; i++) begin
            m_hi[i] = '0;
            m_lo0[i] = '0;
            m_lo1[i] = '0;
        end
        rst = 1'b1;
        write_strobe = 1'b0;
        rw_index = '0;
        asid = '0;
        inst_vaddr = '0;
        data_vaddr = '0;
        entry_hi = '0;
        entry_lo0 = '0;
        entry_lo1 = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < tlb_pkg::TLB_ENTRY_NUM; i++) begin
            r0 = next_random();
            r1 = next_random();
            lookup(tlb_pkg::tlb_index_t'(i), 8'h05, {1'b0, r0[30:0]}, {1'b0, r1[30:0]});
        end

        // Each write is followed by a read-back and a hit on both pages of the pair.
        repeat (NUM_WRITES) begin
            r0 = next_random();
            hi = {1'b0, r0[30:0]};
            lo0 = next_random();
            lo1 = next_random();
            r1 = next_random();
            write_entry(r1[3:0], hi, lo0, lo1);
            lookup(r1[3:0], hi[7:0], {hi[31:13], 1'b0, r1[15:4]}, {hi[31:13], 1'b1, r1[27:16]});
        end

        hi = {19'h12345, 5'b0, 8'h11};
        lo0 = {6'b0, 20'hAB001, 3'd3, 1'b1, 1'b1, 1'b0};
        lo1 = {6'b0, 20'hAB002, 3'd2, 1'b0, 1'b1, 1'b1};
        r0 = {19'h12345, 1'b0, 12'h5A4};
        r1 = {19'h12345, 1'b1, 12'h0C8};
        write_entry(4'd6, hi, lo0, lo1);
        lookup(4'd6, 8'h22, r0, r1);
        lookup(4'd6, 8'h11, r0, r1);
        write_entry(4'd6, hi, lo0 | 32'h1, lo1);
        lookup(4'd6, 8'h22, r0, r1);
        write_entry(4'd2, {19'h12345, 5'b0, 8'h33}, {6'b0, 20'hCD001, 3'd4, 3'b111},
                    {6'b0, 20'hCD002, 3'd5, 3'b011});
        lookup(4'd2, 8'h22, r0, r1);    // Slot 2 shadows slot 6.

        repeat (16) begin
            r0 = next_random();
            r1 = next_random();
            lo0 = next_random() | 32'h1;
            lo1 = next_random() | 32'h1;
            // A global pair covers the data address. The bypass still wins.
            write_entry(r0[3:0], {2'b10, r1[29:13], 5'b0, r0[11:4]}, lo0, lo1);
            lookup(r0[3:0], r1[7:0], {2'b10, r0[29:0]}, {2'b10, r1[29:0]});
        end

        // Only kuseg, kseg0 and kseg1 pairs were written, so these keys find nothing.
        repeat (16) begin
            r0 = next_random();
            probe_key({2'b11, r0[29:0]});
        end

        $display("Checks finished with %0d errors.", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tlb.f ====
src/tlb_pkg.sv
src/tlb_entry_store.sv
src/tlb_lookup.sv
src/tlb_probe.sv
src/tlb.sv
verification/tlb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert -f tlb.f --top-module tlb_tb \
    -o tlb_sim > build.log 2>&1 \
    && ./obj_dir/tlb_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation run failed."; exit 1; }
cat sim.log
grep -q "TESTS PASSED" sim.log \
    && echo "Simulation passed." \
    || { echo "Simulation failed."; exit 1; }
